/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module tb_penalty_game
	verilator --lint-only --timing --assert -f tb.f --top-module penalty_game_top

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_penalty_game -o tb_sim
	./obj_dir/tb_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

/* click_detect.sv */
/* button levels may be asynchronous; each rising edge gives one pulse
   3 cycles later, a held button gives a single pulse */
`timescale 1ns/100ps
`default_nettype none

module click_detect (
    input  logic clk,
    input  logic rst,
    input  logic btn_left,
    input  logic btn_right,
    output logic left_clicked,
    output logic right_clicked
);

    // bit 0 left, bit 1 right
    logic [1:0] btn_meta;
    logic [1:0] btn_sync;
    logic [1:0] btn_prev;
    logic [1:0] click_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            btn_meta <= '0;
            btn_sync <= '0;
            btn_prev <= '0;
            click_q  <= '0;
        end else begin
            // two-flop synchronizer
            btn_meta <= {btn_right, btn_left};
            btn_sync <= btn_meta;
            // last synchronized level
            btn_prev <= btn_sync;
            // rising edge only
            click_q  <= btn_sync & ~btn_prev;
        end
    end

    assign left_clicked  = click_q[0];
    assign right_clicked = click_q[1];

endmodule

`default_nettype wire

/* event_fifo.sv */
/* valid/ready FIFO for any payload type; in_ready drops only when full,
   a write shows at the output one cycle later */
`timescale 1ns/100ps
`default_nettype none
`include "penalty_params.svh"

module event_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = `EVT_DEPTH
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  T     in_data,
    output logic in_ready,
    output logic out_valid,
    output T     out_data,
    input  logic out_ready
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          wr;
    logic          rd;

    assign in_ready  = count != CW'(DEPTH);
    assign out_valid = count != '0;
    assign out_data  = mem[rd_ptr];
    assign wr        = in_valid && in_ready;
    assign rd        = out_valid && out_ready;

    // storage without reset
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap at DEPTH, not a power of two
            if (wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + AW'(1);
            end
            if (rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + AW'(1);
            end
            // occupancy
            count <= count + CW'(wr) - CW'(rd);
        end
    end

    // a write never lands on an unread entry
    no_write_full_a: assert property (@(posedge clk) disable iff (rst)
        wr |-> count == '0 || wr_ptr != rd_ptr);

endmodule

`default_nettype wire

/* game_state_sel.sv */
/* game flow FSM; mode follows solo_enable only in START, so solo_enable
   must be stable a cycle before the start click. MULTI holds START */
`timescale 1ns/100ps
`default_nettype none

module game_state_sel (
    input  logic                clk,
    input  logic                rst,
    input  logic                left_clicked,
    input  logic                right_clicked,
    input  logic                solo_enable,
    input  logic                match_end,
    input  logic                match_result,
    output penalty_pkg::g_state game_state,
    output penalty_pkg::g_mode  game_mode
);

    penalty_pkg::g_state game_state_nxt;
    penalty_pkg::g_mode  game_mode_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            game_state <= penalty_pkg::START;
            game_mode  <= penalty_pkg::MULTI;
        end else begin
            game_state <= game_state_nxt;
            game_mode  <= game_mode_nxt;
        end
    end

    // mode lock while a match runs
    always_comb begin
        if (game_state == penalty_pkg::START) begin
            game_mode_nxt = solo_enable ? penalty_pkg::SOLO : penalty_pkg::MULTI;
        end else begin
            game_mode_nxt = game_mode;
        end
    end

    always_comb begin
        game_state_nxt = game_state;
        if (game_mode == penalty_pkg::SOLO) begin
            case (game_state)
                penalty_pkg::START: begin
                    if (left_clicked) begin
                        game_state_nxt = penalty_pkg::KEEPER;
                    end
                end
                penalty_pkg::KEEPER: begin
                    // result decides the end screen
                    if (match_end) begin
                        game_state_nxt = match_result ? penalty_pkg::WINNER
                                                      : penalty_pkg::LOSER;
                    end
                end
                penalty_pkg::WINNER, penalty_pkg::LOSER: begin
                    if (right_clicked) begin
                        game_state_nxt = penalty_pkg::START;
                    end
                end
                // SHOOTER unreachable in solo play
                default: begin
                    game_state_nxt = penalty_pkg::START;
                end
            endcase
        end else begin
            // no link yet, multiplayer parks in START
            game_state_nxt = penalty_pkg::START;
        end
    end

    // mode frozen for the whole match
    mode_locked_a: assert property (@(posedge clk) disable iff (rst)
        game_state != penalty_pkg::START |=> $stable(game_mode));

    // round engine only ends a match it is playing
    end_in_keeper_a: assert property (@(posedge clk) disable iff (rst)
        match_end |-> game_state == penalty_pkg::KEEPER);

endmodule

`default_nettype wire

/* penalty_game_top.sv */
/* penalty game flow top; solo goalkeeper only, shot events come from
   outside through the shot FIFO, results leave through the result FIFO */
`timescale 1ns/100ps
`default_nettype none

module penalty_game_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    btn_left,
    input  logic                    btn_right,
    input  logic                    solo_enable,
    input  logic                    shot_valid,
    input  penalty_pkg::shot_evt_t  shot_data,
    output logic                    shot_ready,
    output logic                    res_valid,
    output penalty_pkg::match_res_t res_data,
    input  logic                    res_ready,
    output penalty_pkg::g_state     game_state,
    output penalty_pkg::g_mode      game_mode
);

    logic                    left_clicked;
    logic                    right_clicked;
    logic                    match_end;
    logic                    match_result;
    // shot FIFO to round engine
    logic                    sq_valid;
    logic                    sq_ready;
    penalty_pkg::shot_evt_t  sq_data;
    // round engine to result FIFO
    logic                    rec_valid;
    logic                    rec_ready;
    penalty_pkg::match_res_t rec_data;

    click_detect click_i (
        .clk           (clk),
        .rst           (rst),
        .btn_left      (btn_left),
        .btn_right     (btn_right),
        .left_clicked  (left_clicked),
        .right_clicked (right_clicked)
    );

    game_state_sel state_sel_i (
        .clk           (clk),
        .rst           (rst),
        .left_clicked  (left_clicked),
        .right_clicked (right_clicked),
        .solo_enable   (solo_enable),
        .match_end     (match_end),
        .match_result  (match_result),
        .game_state    (game_state),
        .game_mode     (game_mode)
    );

    event_fifo #(.T(penalty_pkg::shot_evt_t)) shot_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (shot_valid),
        .in_data   (shot_data),
        .in_ready  (shot_ready),
        .out_valid (sq_valid),
        .out_data  (sq_data),
        .out_ready (sq_ready)
    );

    penalty_round round_i (
        .clk          (clk),
        .rst          (rst),
        .game_state   (game_state),
        .shot_valid   (sq_valid),
        .shot_data    (sq_data),
        .shot_ready   (sq_ready),
        .res_valid    (rec_valid),
        .res_data     (rec_data),
        .res_ready    (rec_ready),
        .match_end    (match_end),
        .match_result (match_result)
    );

    event_fifo #(.T(penalty_pkg::match_res_t)) res_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (rec_valid),
        .in_data   (rec_data),
        .in_ready  (rec_ready),
        .out_valid (res_valid),
        .out_data  (res_data),
        .out_ready (res_ready)
    );

endmodule

`default_nettype wire

/* penalty_params.svh */
/* game constants; SHOTS_PER_MATCH must stay below 8 to fit the 3-bit
   save and shot counters */
`ifndef PENALTY_PARAMS_SVH
`define PENALTY_PARAMS_SVH

// kicks in one match
`define SHOTS_PER_MATCH 5

// saves needed for a win
`define WIN_SAVES 3

// entries in each event FIFO
`define EVT_DEPTH 4

`endif

/* penalty_pkg.sv */
/* shared types of the penalty game; state and mode encodings must match the
   state selector, struct field order is the on-wire layout of the FIFOs */
`default_nettype none

package penalty_pkg;

    // flow of one game, SHOOTER kept for the multiplayer link
    typedef enum logic [2:0] {
        START,
        KEEPER,
        SHOOTER,
        WINNER,
        LOSER
    } g_state;

    // MULTI is the reset mode
    typedef enum logic {
        SOLO,
        MULTI
    } g_mode;

    // goal zone: 0 left, 1 center-left, 2 center-right, 3 right
    typedef logic [1:0] dir_t;

    // one penalty kick as seen by the round engine
    typedef struct packed {
        dir_t shot_dir;
        dir_t keeper_dir;
    } shot_evt_t;

    // record pushed out when a match ends
    typedef struct packed {
        logic       won;
        logic [2:0] saves;
    } match_res_t;

endpackage

`default_nettype wire

/* penalty_round.sv */
/* round engine; takes shots only in KEEPER, a save is a dive into the shot
   zone. match_end waits until the result record is taken */
`timescale 1ns/100ps
`default_nettype none
`include "penalty_params.svh"

module penalty_round (
    input  logic                    clk,
    input  logic                    rst,
    input  penalty_pkg::g_state     game_state,
    input  logic                    shot_valid,
    input  penalty_pkg::shot_evt_t  shot_data,
    output logic                    shot_ready,
    output logic                    res_valid,
    output penalty_pkg::match_res_t res_data,
    input  logic                    res_ready,
    output logic                    match_end,
    output logic                    match_result
);

    logic [2:0]              shot_cnt;
    logic [2:0]              save_cnt;
    logic [2:0]              saves_nxt;
    logic                    pending;
    logic                    in_keeper;
    logic                    shot_fire;
    logic                    res_fire;
    logic                    last_shot;
    penalty_pkg::match_res_t res_q;

    assign in_keeper  = game_state == penalty_pkg::KEEPER;
    // refuse shots while a result waits
    assign shot_ready = in_keeper && !pending;
    assign shot_fire  = shot_valid && shot_ready;
    assign saves_nxt  = save_cnt + 3'(shot_data.keeper_dir == shot_data.shot_dir);
    assign last_shot  = shot_cnt == 3'(`SHOTS_PER_MATCH - 1);

    assign res_valid = pending;
    assign res_data  = res_q;
    assign res_fire  = res_valid && res_ready;

    // one-cycle pulse in the accept cycle
    assign match_end    = res_fire;
    assign match_result = res_fire && res_q.won;

    always_ff @(posedge clk) begin
        if (rst) begin
            shot_cnt <= '0;
            save_cnt <= '0;
            pending  <= 1'b0;
        end else if (res_fire || !in_keeper) begin
            // idle outside KEEPER, fresh after each match
            shot_cnt <= '0;
            save_cnt <= '0;
            pending  <= 1'b0;
        end else if (shot_fire) begin
            shot_cnt <= shot_cnt + 3'd1;
            save_cnt <= saves_nxt;
            if (last_shot) begin
                pending <= 1'b1;
            end
        end
    end

    // record latched with the final kick
    always_ff @(posedge clk) begin
        if (shot_fire && last_shot) begin
            res_q.won   <= saves_nxt >= 3'(`WIN_SAVES);
            res_q.saves <= saves_nxt;
        end
    end

    shot_cnt_max_a: assert property (@(posedge clk) disable iff (rst)
        shot_cnt <= 3'(`SHOTS_PER_MATCH));

    res_hold_a: assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res_data));

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
penalty_pkg.sv
click_detect.sv
game_state_sel.sv
event_fifo.sv
penalty_round.sv
penalty_game_top.sv
tb_penalty_game.sv

/* tb_penalty_game.sv */
/* directed testbench for the penalty game top; solo play only, shot events come
   from an xorshift generator, the first error ends the run */
`timescale 1ns/100ps
`default_nettype none
`include "penalty_params.svh"

module tb_penalty_game;

    localparam int WAIT_LIMIT = 100;

    logic                    clk;
    logic                    rst;
    logic                    btn_left;
    logic                    btn_right;
    logic                    solo_enable;
    logic                    shot_valid;
    penalty_pkg::shot_evt_t  shot_data;
    logic                    shot_ready;
    logic                    res_valid;
    penalty_pkg::match_res_t res_data;
    logic                    res_ready;
    penalty_pkg::g_state     game_state;
    penalty_pkg::g_mode      game_mode;

    logic [31:0]             rng;
    penalty_pkg::shot_evt_t  shots [`SHOTS_PER_MATCH];

    penalty_game_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .btn_left    (btn_left),
        .btn_right   (btn_right),
        .solo_enable (solo_enable),
        .shot_valid  (shot_valid),
        .shot_data   (shot_data),
        .shot_ready  (shot_ready),
        .res_valid   (res_valid),
        .res_data    (res_data),
        .res_ready   (res_ready),
        .game_state  (game_state),
        .game_mode   (game_mode)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // 6 tests of at most 200 cycles each
    initial begin
        #(6 * 200 * 8);
        $display("watchdog expired before the tests completed");
        $display("Done: errors found");
        $fatal(1);
    end

    function automatic logic [31:0] xorshift_step(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %0t ns %s expected %0h actual %0h", $time, name, expected, actual);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    // bounded wait, polled on the falling edge
    task automatic wait_state(input penalty_pkg::g_state st, input string what);
        int n;
        n = 0;
        while (game_state !== st) begin
            if (n == WAIT_LIMIT) begin
                $display("timeout while waiting for game state %s", what);
                $display("Done: errors found");
                $fatal(1);
            end else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    task automatic click_left();
        btn_left = 1'b1;
        repeat (2) @(negedge clk);
        btn_left = 1'b0;
    endtask

    task automatic click_right();
        btn_right = 1'b1;
        repeat (2) @(negedge clk);
        btn_right = 1'b0;
    endtask

    task automatic start_solo_match();
        solo_enable = 1'b1;
        @(negedge clk);
        click_left();
        wait_state(penalty_pkg::KEEPER, "KEEPER");
    endtask

    // fill shots[], expected record from the save rule
    task automatic make_shots(input logic force_win, output penalty_pkg::match_res_t exp);
        logic [2:0] saves;
        saves = '0;
        for (int i = 0; i < `SHOTS_PER_MATCH; i++) begin
            rng = xorshift_step(rng);
            shots[i].shot_dir = rng[1:0];
            rng = xorshift_step(rng);
            shots[i].keeper_dir = (force_win && i < `WIN_SAVES) ? shots[i].shot_dir : rng[1:0];
            if (shots[i].keeper_dir == shots[i].shot_dir) begin
                saves = saves + 3'd1;
            end
        end
        exp.saves = saves;
        exp.won   = saves >= 3'(`WIN_SAVES);
    endtask

    // transfer lands on the rising edge after ready is seen
    task automatic push_shots(input int lo, input int hi);
        int n;
        for (int i = lo; i < hi; i++) begin
            shot_valid = 1'b1;
            shot_data  = shots[i];
            n = 0;
            while (!shot_ready) begin
                if (n == WAIT_LIMIT) begin
                    $display("timeout while waiting for shot_ready");
                    $display("Done: errors found");
                    $fatal(1);
                end else begin
                    @(negedge clk);
                    n++;
                end
            end
            @(negedge clk);
            shot_valid = 1'b0;
        end
    endtask

    task automatic pop_result(input penalty_pkg::match_res_t exp);
        int n;
        res_ready = 1'b1;
        n = 0;
        while (!res_valid) begin
            if (n == WAIT_LIMIT) begin
                $display("timeout while waiting for res_valid");
                $display("Done: errors found");
                $fatal(1);
            end else begin
                @(negedge clk);
                n++;
            end
        end
        check_value("res_data.won", 32'(exp.won), 32'(res_data.won));
        check_value("res_data.saves", 32'(exp.saves), 32'(res_data.saves));
        @(negedge clk);
        res_ready = 1'b0;
    endtask

    task automatic end_match(input penalty_pkg::match_res_t exp);
        if (exp.won) begin
            wait_state(penalty_pkg::WINNER, "WINNER");
        end else begin
            wait_state(penalty_pkg::LOSER, "LOSER");
        end
    endtask

    task automatic test_reset();
        check_value("game_state", 32'(penalty_pkg::START), 32'(game_state));
        check_value("game_mode", 32'(penalty_pkg::MULTI), 32'(game_mode));
        check_value("res_valid", 32'd0, 32'(res_valid));
        check_value("shot_ready", 32'd1, 32'(shot_ready));
    endtask

    task automatic test_multi_hold();
        solo_enable = 1'b0;
        click_left();
        click_right();
        repeat (6) @(negedge clk);
        check_value("game_state", 32'(penalty_pkg::START), 32'(game_state));
        check_value("game_mode", 32'(penalty_pkg::MULTI), 32'(game_mode));
    endtask

    task automatic test_solo_start();
        start_solo_match();
        check_value("game_mode", 32'(penalty_pkg::SOLO), 32'(game_mode));
        // mode locked during the match
        solo_enable = 1'b0;
        repeat (4) @(negedge clk);
        check_value("game_mode", 32'(penalty_pkg::SOLO), 32'(game_mode));
        check_value("game_state", 32'(penalty_pkg::KEEPER), 32'(game_state));
    endtask

    // continues the match opened by test_solo_start
    task automatic test_win_match();
        penalty_pkg::match_res_t exp;
        make_shots(1'b1, exp);
        push_shots(0, `SHOTS_PER_MATCH);
        end_match(exp);
        pop_result(exp);
        click_right();
        wait_state(penalty_pkg::START, "START");
    endtask

    task automatic test_random_match();
        penalty_pkg::match_res_t exp;
        start_solo_match();
        make_shots(1'b0, exp);
        push_shots(0, `SHOTS_PER_MATCH);
        end_match(exp);
        pop_result(exp);
        click_right();
        wait_state(penalty_pkg::START, "START");
    endtask

    task automatic test_back_pressure();
        penalty_pkg::match_res_t exp_a;
        penalty_pkg::match_res_t exp_b;
        res_ready = 1'b0;
        start_solo_match();
        make_shots(1'b0, exp_a);
        push_shots(0, `SHOTS_PER_MATCH);
        end_match(exp_a);
        click_right();
        wait_state(penalty_pkg::START, "START");
        // shots queued in START stay in the shot FIFO
        make_shots(1'b0, exp_b);
        push_shots(0, `EVT_DEPTH);
        repeat (4) @(negedge clk);
        check_value("shot_ready", 32'd0, 32'(shot_ready));
        check_value("game_state", 32'(penalty_pkg::START), 32'(game_state));
        start_solo_match();
        push_shots(`EVT_DEPTH, `SHOTS_PER_MATCH);
        end_match(exp_b);
        click_right();
        wait_state(penalty_pkg::START, "START");
        check_value("res_valid", 32'd1, 32'(res_valid));
        // oldest record first
        pop_result(exp_a);
        pop_result(exp_b);
        repeat (2) @(negedge clk);
        check_value("res_valid", 32'd0, 32'(res_valid));
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        btn_left    = 1'b0;
        btn_right   = 1'b0;
        solo_enable = 1'b0;
        shot_valid  = 1'b0;
        shot_data   = '0;
        res_ready   = 1'b0;
        rng         = 32'h65430ab5;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        test_reset();
        test_multi_hold();
        test_solo_start();
        test_win_match();
        test_random_match();
        test_back_pressure();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire
